// ==== avg_pool_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

module avg_pool_unit (
    input  wire logic                    clk,
    input  wire logic                    rst,

    // window input from the FIFO
    input  wire logic                    win_valid,
    output logic                         win_ready,
    input  wire pool_types_pkg::pixel_t  p00,
    input  wire pool_types_pkg::pixel_t  p01,
    input  wire pool_types_pkg::pixel_t  p10,
    input  wire pool_types_pkg::pixel_t  p11,
    input  wire logic                    win_last,

    // pooled output stream
    output logic                         out_valid,
    input  wire logic                    out_ready,
    output pool_types_pkg::pixel_t       out_pixel,
    output logic                         out_last
);

    pool_types_pkg::acc_t   win_sum;
    pool_types_pkg::pixel_t win_avg;
    logic                   win_fire;

    assign win_ready = !out_valid || out_ready;    // output stage free or draining
    assign win_fire  = win_valid && win_ready;

    // all four terms sign extended before the add
    assign win_sum = pool_types_pkg::acc_t'(p00) + pool_types_pkg::acc_t'(p01)
                   + pool_types_pkg::acc_t'(p10) + pool_types_pkg::acc_t'(p11);

    // arithmetic shift floors toward minus infinity
    assign win_avg = pool_types_pkg::pixel_t'(win_sum >>> 2);

    // output stage control
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (win_fire) begin
            out_valid <= 1'b1;
            out_last  <= win_last;
        end else if (out_ready) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
    end

    // pooled value held until accepted
    always_ff @(posedge clk) begin
        if (win_fire) begin
            out_pixel <= win_avg;
        end
    end

endmodule

`default_nettype wire

// ==== pool_cfg_pkg.sv ====
`default_nettype none

// geometry and sizing shared by the RTL and the testbench
package pool_cfg_pkg;

    // feature-map pixel word
    localparam int PIX_W = 32;             // bits per pixel

    // default map geometry, both dimensions must be even
    localparam int DEF_FM_W = 6;           // pixels per row
    localparam int DEF_FM_H = 6;           // rows per frame

    // window buffer between former and averager
    localparam int DEF_FIFO_DEPTH = 4;     // windows held in the FIFO memory

endpackage

`default_nettype wire

// ==== pool_layer.sv ====
`default_nettype none
`timescale 1ns/100ps

module pool_layer #(
    parameter int FM_W       = pool_cfg_pkg::DEF_FM_W,
    parameter int FM_H       = pool_cfg_pkg::DEF_FM_H,
    parameter int FIFO_DEPTH = pool_cfg_pkg::DEF_FIFO_DEPTH
) (
    input  wire logic                    clk,
    input  wire logic                    rst,

    input  wire logic                    in_valid,
    output logic                         in_ready,
    input  wire pool_types_pkg::pixel_t  in_pixel,

    output logic                         out_valid,
    input  wire logic                    out_ready,
    output pool_types_pkg::pixel_t       out_pixel,
    output logic                         out_last
);

    // former to FIFO
    logic                   win_valid;
    logic                   win_ready;
    logic                   win_last;
    pool_types_pkg::pixel_t win_p00;
    pool_types_pkg::pixel_t win_p01;
    pool_types_pkg::pixel_t win_p10;
    pool_types_pkg::pixel_t win_p11;
    logic [pool_types_pkg::WIN_PAYLOAD_W-1:0] wdata;

    // FIFO to averager
    logic                   rd_valid;
    logic                   rd_ready;
    logic                   rd_last;
    pool_types_pkg::pixel_t rd_p00;
    pool_types_pkg::pixel_t rd_p01;
    pool_types_pkg::pixel_t rd_p10;
    pool_types_pkg::pixel_t rd_p11;
    logic [pool_types_pkg::WIN_PAYLOAD_W-1:0] rdata;

    assign wdata = {win_last, win_p00, win_p01, win_p10, win_p11};
    assign {rd_last, rd_p00, rd_p01, rd_p10, rd_p11} = rdata;

    window_former #(
        .FM_W (FM_W),
        .FM_H (FM_H)
    ) u_former (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pixel  (in_pixel),
        .win_valid (win_valid),
        .win_ready (win_ready),
        .win_p00   (win_p00),
        .win_p01   (win_p01),
        .win_p10   (win_p10),
        .win_p11   (win_p11),
        .win_last  (win_last)
    );

    window_fifo #(
        .WIDTH (pool_types_pkg::WIN_PAYLOAD_W),
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (win_valid),
        .wr_ready (win_ready),
        .wdata    (wdata),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready),
        .rdata    (rdata)
    );

    avg_pool_unit u_avg (
        .clk       (clk),
        .rst       (rst),
        .win_valid (rd_valid),
        .win_ready (rd_ready),
        .p00       (rd_p00),
        .p01       (rd_p01),
        .p10       (rd_p10),
        .p11       (rd_p11),
        .win_last  (rd_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pixel (out_pixel),
        .out_last  (out_last)
    );

endmodule

`default_nettype wire

// ==== pool_types_pkg.sv ====
`default_nettype none

// data types carried on the pooling streams
package pool_types_pkg;

    // one signed feature-map pixel
    typedef logic signed [pool_cfg_pkg::PIX_W-1:0] pixel_t;

    // four pixels summed, two guard bits so the sum never overflows
    localparam int ACC_W = pool_cfg_pkg::PIX_W + 2;
    typedef logic signed [ACC_W-1:0] acc_t;

    // FIFO entry is {last, p00, p01, p10, p11}
    localparam int WIN_PAYLOAD_W = 4 * pool_cfg_pkg::PIX_W + 1;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the pooling layer testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f sources.f \
    --top-module tb_pool_layer \
    --Mdir obj_dir \
    -o tb_pool_layer
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output="$(./obj_dir/tb_pool_layer)"
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== sources.f ====
pool_cfg_pkg.sv
pool_types_pkg.sv
window_former.sv
window_fifo.sv
avg_pool_unit.sv
pool_layer.sv
tb_pool_layer.sv

// ==== tb_pool_layer.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_pool_layer;

    localparam int FM_W         = pool_cfg_pkg::DEF_FM_W;
    localparam int FM_H         = pool_cfg_pkg::DEF_FM_H;
    localparam int N_PIX        = FM_W * FM_H;
    localparam int OUT_W        = FM_W / 2;
    localparam int OUT_H        = FM_H / 2;
    localparam int OUT_N        = OUT_W * OUT_H;
    localparam int MAX_CYCLES   = 20000;
    localparam int DRAIN_CYCLES = 20;       // idle time to catch extra outputs
    localparam int LOW_CYCLES   = 60;       // long out_ready low phase

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   in_valid;
    logic                   in_ready;
    pool_types_pkg::pixel_t in_pixel;
    logic                   out_valid;
    logic                   out_ready;
    pool_types_pkg::pixel_t out_pixel;
    logic                   out_last;

    int frame_buf [N_PIX];
    int exp_pix [$];
    bit exp_last [$];
    int got_pix [$];
    bit got_last [$];
    int got_base;                           // first output of the current test
    int ready_mode;                         // 0 ready, 1 random, 2 held low
    int stall_cycles = 0;
    int cycle_count = 0;
    int error_count;
    int check_count;

    pool_layer u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pixel  (in_pixel),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pixel (out_pixel),
        .out_last  (out_last)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // output collector
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            got_pix.push_back(out_pixel);
            got_last.push_back(out_last);
        end
    end

    // input stall monitor
    always @(posedge clk) begin
        if (!rst && in_valid && !in_ready) begin
            stall_cycles <= stall_cycles + 1;
        end
    end

    // out_ready driver, changes on the falling edge
    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            case (ready_mode)
                0:       out_ready = 1'b1;
                1:       out_ready = (($urandom % 2) == 1);
                default: out_ready = 1'b0;
            endcase
        end
    end

    // floor of the four-pixel mean, rounded toward minus infinity
    function automatic int floor_avg4(input longint a, input longint b,
                                      input longint c, input longint d);
        longint s;
        longint q;
        s = a + b + c + d;
        q = s / 4;
        if ((s % 4) != 0 && s < 0) begin
            q = q - 1;
        end
        return int'(q);
    endfunction

    task automatic build_expected();
        int base;
        for (int oy = 0; oy < OUT_H; oy++) begin
            for (int ox = 0; ox < OUT_W; ox++) begin
                base = 2 * oy * FM_W + 2 * ox;
                exp_pix.push_back(floor_avg4(frame_buf[base], frame_buf[base + 1],
                                             frame_buf[base + FM_W],
                                             frame_buf[base + FM_W + 1]));
                exp_last.push_back((oy * OUT_W + ox) == OUT_N - 1);
            end
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < N_PIX; i++) begin
            frame_buf[i] = int'($urandom);
        end
    endtask

    // one pixel transfer, called just after a falling edge
    task automatic send_pixel(input int value, input bit gaps);
        int n;
        bit taken;
        if (gaps) begin
            n = int'($urandom % 3);
            in_valid = 1'b0;
            repeat (n) @(negedge clk);
        end
        in_valid = 1'b1;
        in_pixel = value;
        do begin
            taken = in_ready;                      // stable until the next rising edge
            @(negedge clk);
        end while (!taken);
        in_valid = 1'b0;
    endtask

    task automatic send_pixels(input int count, input bit gaps);
        for (int i = 0; i < count; i++) begin
            send_pixel(frame_buf[i], gaps);
        end
    endtask

    task automatic check_results(input string name);
        int n;
        int got_n;
        n = exp_pix.size();
        while (got_pix.size() - got_base < n) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);
        got_n = got_pix.size() - got_base;
        check_count++;
        if (got_n != n) begin
            $display("%s: expected %0d outputs but received %0d", name, n, got_n);
            error_count++;
        end
        for (int k = 0; k < n; k++) begin
            check_count++;
            if (got_pix[got_base + k] != exp_pix[k]) begin
                $display("FAILED %s: output %0d expected %0d actual %0d",
                         name, k, exp_pix[k], got_pix[got_base + k]);
                error_count++;
            end
            if (got_last[got_base + k] != exp_last[k]) begin
                $display("FAILED %s: output %0d last expected %0b actual %0b",
                         name, k, exp_last[k], got_last[got_base + k]);
                error_count++;
            end
        end
        got_base = got_pix.size();
        exp_pix.delete();
        exp_last.delete();
    endtask

    task automatic ramp_frame();
        for (int i = 0; i < N_PIX; i++) begin
            frame_buf[i] = i;
        end
        build_expected();
        send_pixels(N_PIX, 1'b0);
        check_results("ramp_frame");
    endtask

    task automatic negative_floor();
        for (int i = 0; i < N_PIX; i++) begin
            frame_buf[i] = (i % 2 == 0) ? 3 * i + 5 : -(5 * i + 9);  // sums are 2 mod 4
        end
        build_expected();
        send_pixels(N_PIX, 1'b0);
        check_results("negative_floor");
    endtask

    task automatic output_backpressure();
        int stalls_before;
        fill_random();
        build_expected();
        stalls_before = stall_cycles;
        fork
            send_pixels(N_PIX, 1'b0);
            begin
                ready_mode = 2;
                repeat (LOW_CYCLES) @(negedge clk);
                ready_mode = 1;
            end
        join
        check_results("output_backpressure");
        ready_mode = 0;
        check_count++;
        if (stall_cycles == stalls_before) begin
            $display("output_backpressure: in_ready never dropped while out_ready was low");
            error_count++;
        end
    endtask

    task automatic input_gaps_back_to_back();
        fill_random();
        build_expected();
        send_pixels(N_PIX, 1'b1);
        fill_random();
        build_expected();
        send_pixels(N_PIX, 1'b1);
        check_results("input_gaps_back_to_back");
    endtask

    task automatic reset_recovery();
        fill_random();
        ready_mode = 2;                            // windows stay queued in the DUT
        send_pixels(20, 1'b0);                     // stop partway through row 3
        repeat (3) @(negedge clk);
        rst = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_count++;
            if (out_valid) begin
                $display("reset_recovery: out_valid high while reset is held");
                error_count++;
            end
        end
        rst = 1'b0;
        ready_mode = 0;
        got_base = got_pix.size();                 // drop anything from the cut frame
        fill_random();
        build_expected();
        send_pixels(N_PIX, 1'b0);
        check_results("reset_recovery");
    endtask

    initial begin
        void'($urandom(55604));
        rst = 1'b1;
        in_valid = 1'b0;
        in_pixel = '0;
        ready_mode = 0;
        got_base = 0;
        error_count = 0;
        check_count = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        ramp_frame();
        negative_floor();
        output_backpressure();
        input_gaps_back_to_back();
        reset_recovery();
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== window_fifo.sv ====
`default_nettype none
`timescale 1ns/100ps

module window_fifo #(
    parameter int WIDTH = pool_types_pkg::WIN_PAYLOAD_W,
    parameter int DEPTH = pool_cfg_pkg::DEF_FIFO_DEPTH
) (
    input  wire logic             clk,
    input  wire logic             rst,

    input  wire logic             wr_valid,
    output logic                  wr_ready,
    input  wire logic [WIDTH-1:0] wdata,

    output logic                  rd_valid,
    input  wire logic             rd_ready,
    output logic      [WIDTH-1:0] rdata
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;           // entries in mem, output register not counted
    logic             wr_fire;
    logic             out_load;        // output register free this cycle
    logic             pop;
    logic             bypass;          // write straight into the output register
    logic             push;

    assign wr_ready = (count != CNT_W'(DEPTH));
    assign wr_fire  = wr_valid && wr_ready;
    assign out_load = !rd_valid || rd_ready;
    assign pop      = out_load && (count != '0);
    assign bypass   = out_load && (count == '0) && wr_fire;
    assign push     = wr_fire && !bypass;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
            if (out_load) begin
                rd_valid <= pop || bypass;
            end
        end
    end

    // storage and registered read data
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
        if (pop) begin
            rdata <= mem[rd_ptr];
        end else if (bypass) begin
            rdata <= wdata;            // empty FIFO, skip the memory
        end
    end

endmodule

`default_nettype wire

// ==== window_former.sv ====
`default_nettype none
`timescale 1ns/100ps

module window_former #(
    parameter int FM_W = pool_cfg_pkg::DEF_FM_W,
    parameter int FM_H = pool_cfg_pkg::DEF_FM_H
) (
    input  wire logic                    clk,
    input  wire logic                    rst,

    // row-major pixel stream
    input  wire logic                    in_valid,
    output logic                         in_ready,
    input  wire pool_types_pkg::pixel_t  in_pixel,

    // 2x2 window stream
    output logic                         win_valid,
    input  wire logic                    win_ready,
    output pool_types_pkg::pixel_t       win_p00,   // upper left
    output pool_types_pkg::pixel_t       win_p01,   // upper right
    output pool_types_pkg::pixel_t       win_p10,   // lower left
    output pool_types_pkg::pixel_t       win_p11,   // lower right
    output logic                         win_last
);

    localparam int COL_W = (FM_W > 1) ? $clog2(FM_W) : 1;
    localparam int ROW_W = (FM_H > 1) ? $clog2(FM_H) : 1;

    logic [COL_W-1:0] col_q;                       // column of the next pixel
    logic [ROW_W-1:0] row_q;                       // row of the next pixel
    logic [COL_W-1:0] col_prev;
    logic             col_last;
    logic             row_last;
    logic             in_fire;
    logic             win_load;

    pool_types_pkg::pixel_t line_buf [FM_W];       // upper row of the window pair
    pool_types_pkg::pixel_t hold_pix;              // left pixel of the lower row

    // window register may be refilled once it is empty or being taken
    assign in_ready = !win_valid || win_ready;
    assign in_fire  = in_valid && in_ready;

    assign col_last = (col_q == COL_W'(FM_W - 1));
    assign row_last = (row_q == ROW_W'(FM_H - 1));
    assign col_prev = col_q - 1'b1;                // col_q is odd when used

    // odd row and odd column closes a window
    assign win_load = in_fire && row_q[0] && col_q[0];

    // position counters, wrap at end of frame
    always_ff @(posedge clk) begin
        if (rst) begin
            col_q <= '0;
            row_q <= '0;
        end else if (in_fire) begin
            if (col_last) begin
                col_q <= '0;
                row_q <= row_last ? '0 : row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // even rows fill the line buffer, odd rows park the left pixel
    always_ff @(posedge clk) begin
        if (in_fire) begin
            if (!row_q[0]) begin
                line_buf[col_q] <= in_pixel;
            end else if (!col_q[0]) begin
                hold_pix <= in_pixel;
            end
        end
    end

    // window valid flag
    always_ff @(posedge clk) begin
        if (rst) begin
            win_valid <= 1'b0;
        end else if (win_load) begin
            win_valid <= 1'b1;
        end else if (win_ready) begin
            win_valid <= 1'b0;                     // current window taken
        end
    end

    // window payload
    always_ff @(posedge clk) begin
        if (win_load) begin
            win_p00  <= line_buf[col_prev];
            win_p01  <= line_buf[col_q];
            win_p10  <= hold_pix;
            win_p11  <= in_pixel;
            win_last <= row_last && col_last;      // final pixel of the frame
        end
    end

endmodule

`default_nettype wire
